//--- Makefile
# build and run the cart_main testbench with Verilator

OBJ := obj_dir
LOG := sim.log

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert -j 0 --top-module tb_top -Mdir $(OBJ) -f sim.f
	./$(OBJ)/Vtb_top | tee $(LOG)
	grep -q "^TEST RESULT: PASS$$" $(LOG)

lint:
	verilator --lint-only --timing --top-module tb_top -f sim.f

clean:
	rm -rf $(OBJ) $(LOG)

//--- sim.f
src/cart_pkg.sv
src/snes_bus_decode.sv
src/mcu_rom_arbiter.sv
src/psram_port.sv
src/cart_main.sv
testbench/tb_checker.sv
testbench/tb_top.sv

//--- src/cart_main.sv
module cart_main #(
  parameter int rom_cycle_len = 8,
  parameter int dead_timeout  = 96000
) (
  input  logic                        CLK2,
  input  logic                        rst_n,
  input  logic [cart_pkg::addr_w-1:0] snes_addr,
  input  logic [cart_pkg::data_w-1:0] snes_data_in,
  input  logic                        snes_rd_n,
  input  logic                        snes_wr_n,
  input  logic                        snes_cpu_clk,
  input  logic                        rom_hit,
  input  logic                        is_writable,
  input  logic [cart_pkg::addr_w-1:0] mapped_addr,
  input  logic [cart_pkg::word_w-1:0] rom_data_in,
  input  logic [cart_pkg::addr_w-1:0] mcu_addr,
  input  logic [cart_pkg::data_w-1:0] mcu_dout,
  input  logic                        mcu_rrq,
  input  logic                        mcu_wrq,
  output logic [cart_pkg::addr_w-2:0] rom_addr,
  output logic [cart_pkg::word_w-1:0] rom_data_out,
  output logic                        rom_data_oe_lo,
  output logic                        rom_data_oe_hi,
  output logic                        rom_we_n,
  output logic                        rom_bhe_n,
  output logic                        rom_ble_n,
  output logic [cart_pkg::data_w-1:0] snes_data_out,
  output logic                        snes_data_oe,
  output logic [cart_pkg::data_w-1:0] mcu_din,
  output logic                        mcu_rdy
);

  logic [cart_pkg::data_w-1:0] bus_data;
  logic                        bus_rd_n;
  logic                        bus_wr_n;
  logic                        bus_clk;
  logic                        bus_clk_raw;
  logic                        cycle_start;
  logic                        cycle_end;
  cart_pkg::rom_addr_u         mcu_addr_latched;
  logic                        mcu_hit;
  logic                        mcu_wr_hit;
  logic [cart_pkg::data_w-1:0] rom_byte;

  // addr and the rd/wr strobes feed the mapper and register blocks outside
  snes_bus_decode u_decode (
    .CLK2         (CLK2),
    .rst_n        (rst_n),
    .snes_addr    (snes_addr),
    .snes_data_in (snes_data_in),
    .snes_rd_n    (snes_rd_n),
    .snes_wr_n    (snes_wr_n),
    .snes_cpu_clk (snes_cpu_clk),
    .addr         (),
    .data         (bus_data),
    .rd_n         (bus_rd_n),
    .wr_n         (bus_wr_n),
    .cpu_clk      (bus_clk),
    .cpu_clk_raw  (bus_clk_raw),
    .cycle_start  (cycle_start),
    .cycle_end    (cycle_end),
    .rd_start     (),
    .wr_end       ()
  );

  mcu_rom_arbiter #(
    .rom_cycle_len (rom_cycle_len),
    .dead_timeout  (dead_timeout)
  ) u_arbiter (
    .CLK2             (CLK2),
    .rst_n            (rst_n),
    .cycle_start      (cycle_start),
    .cycle_end        (cycle_end),
    .cpu_clk_raw      (bus_clk_raw),
    .rom_hit          (rom_hit),
    .mcu_addr         (mcu_addr),
    .mcu_rrq          (mcu_rrq),
    .mcu_wrq          (mcu_wrq),
    .rom_byte         (rom_byte),
    .mcu_addr_latched (mcu_addr_latched),
    .mcu_hit          (mcu_hit),
    .mcu_wr_hit       (mcu_wr_hit),
    .mcu_din          (mcu_din),
    .mcu_rdy          (mcu_rdy)
  );

  psram_port u_port (
    .mapped_addr      (mapped_addr),
    .mcu_addr_latched (mcu_addr_latched),
    .mcu_hit          (mcu_hit),
    .mcu_wr_hit       (mcu_wr_hit),
    .rom_hit          (rom_hit),
    .is_writable      (is_writable),
    .rd_n             (bus_rd_n),
    .wr_n             (bus_wr_n),
    .cpu_clk          (bus_clk),
    .snes_data        (bus_data),
    .mcu_dout         (mcu_dout),
    .rom_data_in      (rom_data_in),
    .rom_addr         (rom_addr),
    .rom_byte         (rom_byte),
    .rom_data_out     (rom_data_out),
    .rom_data_oe_lo   (rom_data_oe_lo),
    .rom_data_oe_hi   (rom_data_oe_hi),
    .rom_we_n         (rom_we_n),
    .rom_bhe_n        (rom_bhe_n),
    .rom_ble_n        (rom_ble_n),
    .snes_data_out    (snes_data_out),
    .snes_data_oe     (snes_data_oe)
  );

endmodule

//--- src/cart_pkg.sv
package cart_pkg;

  localparam int addr_w     = 24;  // console byte address
  localparam int data_w     = 8;
  localparam int word_w     = 16;  // psram data bus
  localparam int sync_depth = 8;   // taps per bus sampling chain

  //////////////////////////////
  // arbiter states, one-hot
  //////////////////////////////
  typedef enum logic [4:0] {
    st_idle    = 5'b00001,
    st_rd_addr = 5'b00010,
    st_rd_end  = 5'b00100,
    st_wr_addr = 5'b01000,
    st_wr_end  = 5'b10000
  } arb_state_t;

  // same 24 bits, either as byte address or split for the 16-bit psram
  typedef union packed {
    logic [addr_w-1:0] byte_addr;
    struct packed {
      logic [addr_w-2:0] word;     // psram word address
      logic              lo_byte;  // set selects the low lane
    } split;
  } rom_addr_u;

endpackage

//--- src/mcu_rom_arbiter.sv
module mcu_rom_arbiter #(
  parameter int rom_cycle_len = 8,
  parameter int dead_timeout  = 96000
) (
  input  logic                        CLK2,
  input  logic                        rst_n,
  input  logic                        cycle_start,
  input  logic                        cycle_end,
  input  logic                        cpu_clk_raw,
  input  logic                        rom_hit,
  input  logic [cart_pkg::addr_w-1:0] mcu_addr,
  input  logic                        mcu_rrq,
  input  logic                        mcu_wrq,
  input  logic [cart_pkg::data_w-1:0] rom_byte,
  output cart_pkg::rom_addr_u         mcu_addr_latched,
  output logic                        mcu_hit,
  output logic                        mcu_wr_hit,
  output logic [cart_pkg::data_w-1:0] mcu_din,
  output logic                        mcu_rdy
);

  localparam int dead_w  = $clog2(dead_timeout + 2);
  localparam int delay_w = $clog2(rom_cycle_len + 1);

  cart_pkg::arb_state_t state;
  logic                 rd_pend;
  logic                 wr_pend;
  logic                 free_strobe;
  logic                 free_slot;
  logic                 dead;
  logic                 accept;
  logic                 at_end;
  logic [dead_w-1:0]    dead_cnt;
  logic [delay_w-1:0]   delay;

  assign accept     = mcu_rdy & (mcu_rrq | mcu_wrq);
  assign at_end     = (state == cart_pkg::st_rd_end) | (state == cart_pkg::st_wr_end);
  assign mcu_wr_hit = (state == cart_pkg::st_wr_addr);
  assign mcu_hit    = mcu_wr_hit | (state == cart_pkg::st_rd_addr);
  assign free_slot  = cycle_end | free_strobe;

  //////////////////////////////
  // request latch
  //////////////////////////////
  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      mcu_rdy <= 1'b1;
    end else if (accept) begin
      rd_pend <= mcu_rrq;          // read wins if both are raised
      wr_pend <= ~mcu_rrq;
      mcu_rdy <= 1'b0;
    end else if (at_end) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      mcu_rdy <= 1'b1;
    end
  end

  always_ff @(posedge CLK2) begin
    if (accept) begin
      mcu_addr_latched.byte_addr <= mcu_addr;
    end
  end

  //////////////////////////////
  // free slot and dead console
  //////////////////////////////
  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      free_strobe <= 1'b0;
      dead_cnt    <= '0;
      dead        <= 1'b1;  // usable before the console runs
    end else begin
      free_strobe <= cycle_start & ~rom_hit;  // console not using rom this cycle
      if (cpu_clk_raw) begin
        dead_cnt <= '0;
        dead     <= 1'b0;
      end else begin
        if (dead_cnt != '1) begin
          dead_cnt <= dead_cnt + 1'b1;  // saturate
        end
        if (dead_cnt > dead_w'(dead_timeout)) begin
          dead <= 1'b1;
        end
      end
    end
  end

  //////////////////////////////
  // access fsm
  //////////////////////////////
  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      state <= cart_pkg::st_idle;
      delay <= '0;
    end else if (dead && cpu_clk_raw) begin
      state <= cart_pkg::st_idle;  // console woke up, replay the access
    end else begin
      case (state)
        cart_pkg::st_idle: begin
          if (free_slot || dead) begin
            if (rd_pend) begin
              state <= cart_pkg::st_rd_addr;
              delay <= delay_w'(rom_cycle_len);
            end else if (wr_pend) begin
              state <= cart_pkg::st_wr_addr;
              delay <= delay_w'(rom_cycle_len);
            end
          end
        end
        cart_pkg::st_rd_addr: begin
          delay <= delay - 1'b1;
          if (delay == '0) state <= cart_pkg::st_rd_end;
        end
        cart_pkg::st_wr_addr: begin
          delay <= delay - 1'b1;
          if (delay == '0) state <= cart_pkg::st_wr_end;
        end
        default: state <= cart_pkg::st_idle;  // both end states
      endcase
    end
  end

  always_ff @(posedge CLK2) begin
    if (state == cart_pkg::st_rd_addr) begin
      mcu_din <= rom_byte;  // last sample before rd_end is kept
    end
  end

  a_state_onehot : assert property (
    @(posedge CLK2) disable iff (!rst_n) $onehot(state)
  ) else $error("arbiter state not one-hot");

  a_busy_not_ready : assert property (
    @(posedge CLK2) disable iff (!rst_n)
    (state != cart_pkg::st_idle) |-> !mcu_rdy
  ) else $error("mcu_rdy high during an access");

endmodule

//--- src/psram_port.sv
module psram_port (
  input  logic [cart_pkg::addr_w-1:0] mapped_addr,
  input  cart_pkg::rom_addr_u         mcu_addr_latched,
  input  logic                        mcu_hit,
  input  logic                        mcu_wr_hit,
  input  logic                        rom_hit,
  input  logic                        is_writable,
  input  logic                        rd_n,
  input  logic                        wr_n,
  input  logic                        cpu_clk,
  input  logic [cart_pkg::data_w-1:0] snes_data,
  input  logic [cart_pkg::data_w-1:0] mcu_dout,
  input  logic [cart_pkg::word_w-1:0] rom_data_in,
  output logic [cart_pkg::addr_w-2:0] rom_addr,
  output logic [cart_pkg::data_w-1:0] rom_byte,
  output logic [cart_pkg::word_w-1:0] rom_data_out,
  output logic                        rom_data_oe_lo,
  output logic                        rom_data_oe_hi,
  output logic                        rom_we_n,
  output logic                        rom_bhe_n,
  output logic                        rom_ble_n,
  output logic [cart_pkg::data_w-1:0] snes_data_out,
  output logic                        snes_data_oe
);

  cart_pkg::rom_addr_u         sel_addr;
  logic                        lo;
  logic                        snes_wr;
  logic                        drive;
  logic [cart_pkg::data_w-1:0] wr_byte;

  // mcu owns the bus only during its address states
  always_comb begin
    sel_addr.byte_addr = mcu_hit ? mcu_addr_latched.byte_addr : mapped_addr;
  end

  assign rom_addr = sel_addr.split.word;
  assign lo       = sel_addr.split.lo_byte;

  assign rom_byte = lo ? rom_data_in[7:0] : rom_data_in[15:8];

  //////////////////////////////
  // write path
  //////////////////////////////
  assign snes_wr = rom_hit & ~wr_n;
  assign drive   = snes_wr | mcu_wr_hit;
  assign wr_byte = snes_wr ? snes_data : mcu_dout;

  assign rom_data_out = {wr_byte, wr_byte};  // oe picks the lane

  always_comb begin
    rom_data_oe_lo = drive & lo;
    rom_data_oe_hi = drive & ~lo;
    a_one_lane : assert (!(rom_data_oe_lo && rom_data_oe_hi))
      else $error("both psram lanes driven");
  end

  // console write strobe only while cpu clock high
  assign rom_we_n = (rom_hit & is_writable & cpu_clk) ? wr_n
                  : mcu_wr_hit ? 1'b0
                  : 1'b1;

  assign rom_bhe_n = lo;
  assign rom_ble_n = ~lo;

  //////////////////////////////
  // console read side
  //////////////////////////////
  assign snes_data_out = rom_byte;
  assign snes_data_oe  = rom_hit & ~rd_n;

endmodule

//--- src/snes_bus_decode.sv
module snes_bus_decode (
  input  logic                        CLK2,
  input  logic                        rst_n,
  input  logic [cart_pkg::addr_w-1:0] snes_addr,
  input  logic [cart_pkg::data_w-1:0] snes_data_in,
  input  logic                        snes_rd_n,
  input  logic                        snes_wr_n,
  input  logic                        snes_cpu_clk,
  output logic [cart_pkg::addr_w-1:0] addr,
  output logic [cart_pkg::data_w-1:0] data,
  output logic                        rd_n,
  output logic                        wr_n,
  output logic                        cpu_clk,
  output logic                        cpu_clk_raw,
  output logic                        cycle_start,
  output logic                        cycle_end,
  output logic                        rd_start,
  output logic                        wr_end
);

  localparam int depth = cart_pkg::sync_depth;

  logic [depth-1:0]            rd_sr;
  logic [depth-1:0]            wr_sr;
  logic [depth-1:0]            clk_sr;
  logic [cart_pkg::addr_w-1:0] addr_sr [depth];
  logic [cart_pkg::data_w-1:0] data_sr [depth];

  //////////////////////////////
  // sampling chains
  //////////////////////////////
  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      rd_sr  <= '1;  // bus idle
      wr_sr  <= '1;
      clk_sr <= '0;
    end else begin
      rd_sr  <= {rd_sr[depth-2:0], snes_rd_n};
      wr_sr  <= {wr_sr[depth-2:0], snes_wr_n};
      clk_sr <= {clk_sr[depth-2:0], snes_cpu_clk};
    end
  end

  always_ff @(posedge CLK2) begin
    addr_sr[0] <= snes_addr;
    data_sr[0] <= snes_data_in;
    for (int i = 1; i < depth; i++) begin
      addr_sr[i] <= addr_sr[i-1];
      data_sr[i] <= data_sr[i-1];
    end
  end

  // glitch filter, a single low tap pulls the level low
  assign addr    = addr_sr[2] & addr_sr[1];
  assign data    = data_sr[2] & data_sr[1];
  assign rd_n    = rd_sr[2] & rd_sr[1];
  assign wr_n    = wr_sr[2] & wr_sr[1];
  assign cpu_clk = clk_sr[2] & clk_sr[1];

  assign cpu_clk_raw = clk_sr[1];  // early tap for dead detection

  // new level must hold for five taps before the strobe fires
  assign cycle_start = (clk_sr[6:1] == 6'b011111);
  assign cycle_end   = (clk_sr[6:1] == 6'b100000);
  assign rd_start    = (rd_sr[6:1] == 6'b100000);
  assign wr_end      = (wr_sr[6:1] == 6'b011111);

  //////////////////////////////
  // checks
  //////////////////////////////
  // the filter keeps start and end at least five cycles apart
  a_clk_edges_apart : assert property (
    @(posedge CLK2) disable iff (!rst_n)
    cycle_start |-> !cycle_end ##1 !cycle_end [*4]
  ) else $error("cycle_end too close to cycle_start");

endmodule

//--- testbench/cart_vectors.txt
# op addr data exp (hex); snes_wr uses exp as the is_writable flag
# idle: addr 1 starts the console clock, addr 0 stops it
mcu_wr 000010 3c 00
mcu_rd 000010 00 3c
mcu_rd 000011 00 48
mcu_wr 000021 5a 00
mcu_rd 000021 00 5a
mcu_rd 000020 00 90
mcu_wr 000006 a7 00
mcu_rd 000006 00 a7
mcu_rd 000007 00 43
idle   000001 00 00
mcu_rd 000010 00 3c
mcu_wr 000030 e1 00
mcu_rd 000030 00 e1
mcu_rd 000031 00 58
snes_rd 000004 00 82
snes_rd 00000b 00 45
snes_rd 000021 00 5a
snes_rd 000010 00 3c
snes_wr 000040 77 01
snes_rd 000040 00 77
snes_wr 000041 88 00
snes_wr 000043 99 01
idle   000000 00 00
mcu_rd 000041 00 60
mcu_rd 000040 00 77
mcu_rd 000043 00 99
mcu_rd 000042 00 a1

//--- testbench/tb_checker.sv
module tb_checker (
  input  logic       CLK2,
  input  logic       rst_n,
  input  logic       mcu_rdy,
  input  logic [7:0] mcu_din,
  input  logic       snes_data_oe,
  input  logic [7:0] snes_data_out,
  input  logic       mcu_exp_en,
  input  logic [7:0] mcu_exp,
  input  logic       snes_exp_en,
  input  logic [7:0] snes_exp,
  output int         errors,
  output int         checks
);

  int   cmp_errors  = 0;
  int   miss_errors = 0;
  int   mcu_seen    = 0;
  int   snes_seen   = 0;
  int   mcu_base    = 0;
  int   snes_base   = 0;
  logic rdy_q       = 1'b1;
  logic oe_q        = 1'b0;
  logic mcu_en_q    = 1'b0;
  logic snes_en_q   = 1'b0;
  logic reset_done  = 1'b0;

  assign errors = cmp_errors + miss_errors;

  //////////////////////////////
  // data compares, on the quiet edge
  //////////////////////////////
  always @(negedge CLK2) begin
    if (rst_n) begin
      rdy_q <= mcu_rdy;
      oe_q  <= snes_data_oe;
      if (!reset_done) begin  // first look after reset
        reset_done <= 1'b1;
        checks++;
        if (!mcu_rdy || snes_data_oe) begin
          $display("error %0t: after reset mcu_rdy=%b snes_data_oe=%b", $time,
                   mcu_rdy, snes_data_oe);
          cmp_errors++;
        end
      end
      if (mcu_rdy && !rdy_q && mcu_exp_en) begin
        checks++;
        mcu_seen++;
        if (mcu_din !== mcu_exp) begin
          $display("error %0t: mcu read got %h, expected %h", $time, mcu_din, mcu_exp);
          cmp_errors++;
        end
      end
      if (snes_data_oe && !oe_q && snes_exp_en) begin
        checks++;
        snes_seen++;
        if (snes_data_out !== snes_exp) begin
          $display("error %0t: console read got %h, expected %h", $time,
                   snes_data_out, snes_exp);
          cmp_errors++;
        end
      end
    end
  end

  // a read window that closes without any compare is a failure too
  always @(posedge CLK2) begin
    mcu_en_q  <= mcu_exp_en;
    snes_en_q <= snes_exp_en;
    if (mcu_exp_en && !mcu_en_q) mcu_base <= mcu_seen;
    if (snes_exp_en && !snes_en_q) snes_base <= snes_seen;
    if (!mcu_exp_en && mcu_en_q && mcu_seen == mcu_base) begin
      $display("mcu read at %0t finished without returning data", $time);
      miss_errors++;
    end
    if (!snes_exp_en && snes_en_q && snes_seen == snes_base) begin
      $display("console read at %0t never enabled the data bus", $time);
      miss_errors++;
    end
  end

endmodule

//--- testbench/tb_top.sv
module tb_top;

  localparam int console_half = 24;    // CLK2 cycles per console clock phase
  localparam int wait_limit   = 2000;

  logic        CLK2         = 1'b0;
  logic        rst_n;
  logic [23:0] snes_addr;
  logic [7:0]  snes_data_in;
  logic        snes_rd_n;
  logic        snes_wr_n;
  logic        snes_cpu_clk = 1'b0;
  logic        rom_hit;
  logic        is_writable;
  logic [23:0] mapped_addr;
  logic [15:0] rom_data_in;
  logic [23:0] mcu_addr;
  logic [7:0]  mcu_dout;
  logic        mcu_rrq;
  logic        mcu_wrq;
  logic [22:0] rom_addr;
  logic [15:0] rom_data_out;
  logic        rom_data_oe_lo;
  logic        rom_data_oe_hi;
  logic        rom_we_n;
  logic        rom_bhe_n;
  logic        rom_ble_n;
  logic [7:0]  snes_data_out;
  logic        snes_data_oe;
  logic [7:0]  mcu_din;
  logic        mcu_rdy;

  logic        console_run;
  int          console_cnt = 0;
  logic        mcu_exp_en;
  logic [7:0]  mcu_exp;
  logic        snes_exp_en;
  logic [7:0]  snes_exp;
  int          errors;
  int          checks;
  int          aborts = 0;
  logic [15:0] psram [64];

  always #4 CLK2 = ~CLK2;

  cart_main #(
    .rom_cycle_len (8),
    .dead_timeout  (200)
  ) i_dut (
    .CLK2 (CLK2), .rst_n (rst_n),
    .snes_addr (snes_addr), .snes_data_in (snes_data_in),
    .snes_rd_n (snes_rd_n), .snes_wr_n (snes_wr_n), .snes_cpu_clk (snes_cpu_clk),
    .rom_hit (rom_hit), .is_writable (is_writable), .mapped_addr (mapped_addr),
    .rom_data_in (rom_data_in), .mcu_addr (mcu_addr), .mcu_dout (mcu_dout),
    .mcu_rrq (mcu_rrq), .mcu_wrq (mcu_wrq), .rom_addr (rom_addr),
    .rom_data_out (rom_data_out), .rom_data_oe_lo (rom_data_oe_lo),
    .rom_data_oe_hi (rom_data_oe_hi), .rom_we_n (rom_we_n),
    .rom_bhe_n (rom_bhe_n), .rom_ble_n (rom_ble_n),
    .snes_data_out (snes_data_out), .snes_data_oe (snes_data_oe),
    .mcu_din (mcu_din), .mcu_rdy (mcu_rdy)
  );

  tb_checker u_checker (
    .CLK2 (CLK2), .rst_n (rst_n), .mcu_rdy (mcu_rdy), .mcu_din (mcu_din),
    .snes_data_oe (snes_data_oe), .snes_data_out (snes_data_out),
    .mcu_exp_en (mcu_exp_en), .mcu_exp (mcu_exp),
    .snes_exp_en (snes_exp_en), .snes_exp (snes_exp),
    .errors (errors), .checks (checks)
  );

  //////////////////////////////
  // psram model, 64 words
  //////////////////////////////
  initial begin
    for (int i = 0; i < 64; i++) begin
      psram[i] = {8'(i) ^ 8'h80, 8'(i) ^ 8'h40};  // hi 8x, lo 4x
    end
  end

  assign rom_data_in = psram[rom_addr[5:0]];

  always @(posedge CLK2) begin
    if (!rom_we_n) begin
      // a lane the dut does not drive stores garbage
      if (!rom_ble_n) begin
        psram[rom_addr[5:0]][7:0] <= rom_data_oe_lo ? rom_data_out[7:0] : 8'hxx;
      end
      if (!rom_bhe_n) begin
        psram[rom_addr[5:0]][15:8] <= rom_data_oe_hi ? rom_data_out[15:8] : 8'hxx;
      end
    end
  end

  // console clock, held low while stopped
  always @(negedge CLK2) begin
    if (!console_run) begin
      snes_cpu_clk <= 1'b0;
      console_cnt  <= 0;
    end else if (console_cnt == console_half - 1) begin
      snes_cpu_clk <= ~snes_cpu_clk;
      console_cnt  <= 0;
    end else begin
      console_cnt <= console_cnt + 1;
    end
  end

  task automatic report_abort(input string msg);
    $display("aborted at %0t: %s", $time, msg);
    aborts++;
  endtask

  task automatic wait_rdy(output bit ok);
    ok = 1'b0;
    for (int n = 0; n < wait_limit; n++) begin
      @(negedge CLK2);
      if (mcu_rdy) begin
        ok = 1'b1;
        break;
      end
    end
  endtask

  task automatic wait_console(input logic lvl, output bit ok);
    ok = 1'b0;
    for (int n = 0; n < wait_limit; n++) begin
      @(posedge CLK2);
      if (snes_cpu_clk == lvl) begin
        ok = 1'b1;
        break;
      end
    end
  endtask

  //////////////////////////////
  // bus operations
  //////////////////////////////
  task automatic mcu_access(input bit is_wr, input logic [23:0] a, input logic [7:0] d,
                            input logic [7:0] e);
    bit ok;
    wait_rdy(ok);
    if (!ok) begin
      report_abort("mcu_rdy stayed low before a request");
      return;
    end
    mcu_addr   = a;
    mcu_dout   = d;
    mcu_exp    = e;
    mcu_exp_en = !is_wr;
    mcu_wrq    = is_wr;
    mcu_rrq    = !is_wr;
    @(negedge CLK2);
    mcu_rrq = 1'b0;
    mcu_wrq = 1'b0;
    wait_rdy(ok);
    if (!ok) begin
      report_abort("mcu access never finished");
      return;
    end
    @(negedge CLK2);  // checker has seen the rising edge
    mcu_exp_en = 1'b0;
  endtask

  task automatic console_access(input bit is_wr, input logic [23:0] a,
                                input logic [7:0] d, input logic [7:0] e);
    bit ok;
    wait_console(1'b1, ok);
    if (ok) wait_console(1'b0, ok);
    if (!ok) begin
      report_abort("console clock is not toggling");
      return;
    end
    @(negedge CLK2);
    snes_addr   = a | 24'hc00000;  // bank c0, mapper strips it
    mapped_addr = a;
    rom_hit     = 1'b1;
    if (is_wr) begin
      is_writable  = e[0];
      snes_data_in = d;
      snes_wr_n    = 1'b0;
    end else begin
      snes_exp    = e;
      snes_exp_en = 1'b1;
      snes_rd_n   = 1'b0;
    end
    wait_console(1'b1, ok);
    if (ok) wait_console(1'b0, ok);
    if (!ok) begin
      report_abort("console cycle did not complete");
      return;
    end
    @(negedge CLK2);
    snes_rd_n   = 1'b1;
    snes_wr_n   = 1'b1;
    rom_hit     = 1'b0;
    is_writable = 1'b0;
    snes_exp_en = 1'b0;
  endtask

  initial begin
    int          fd;
    int          n;
    int          seed;
    int          gap;
    string       line;
    logic [63:0] op;
    logic [23:0] a;
    logic [7:0]  d;
    logic [7:0]  e;
    seed         = $urandom(12);
    rst_n        = 1'b0;
    snes_addr    = '0;
    snes_data_in = '0;
    snes_rd_n    = 1'b1;
    snes_wr_n    = 1'b1;
    rom_hit      = 1'b0;
    is_writable  = 1'b0;
    mapped_addr  = '0;
    mcu_addr     = '0;
    mcu_dout     = '0;
    mcu_rrq      = 1'b0;
    mcu_wrq      = 1'b0;
    console_run  = 1'b0;
    mcu_exp_en   = 1'b0;
    mcu_exp      = '0;
    snes_exp_en  = 1'b0;
    snes_exp     = '0;
    repeat (8) @(negedge CLK2);
    rst_n = 1'b1;
    repeat (4) @(negedge CLK2);

    fd = $fopen("testbench/cart_vectors.txt", "r");
    if (fd == 0) report_abort("cannot open testbench/cart_vectors.txt");
    while (aborts == 0 && !$feof(fd)) begin
      if ($fgets(line, fd) == 0) break;
      n = $sscanf(line, "%s %h %h %h", op, a, d, e);
      if (n == 4) begin
        if (op == "mcu_rd") mcu_access(1'b0, a, d, e);
        else if (op == "mcu_wr") mcu_access(1'b1, a, d, e);
        else if (op == "snes_rd") console_access(1'b0, a, d, e);
        else if (op == "snes_wr") console_access(1'b1, a, d, e);
        else if (op == "idle") begin
          console_run = a[0];
          gap = 20 + int'($urandom % 40);
          repeat (gap) @(negedge CLK2);
        end else begin
          report_abort("unknown operation in vector file");
        end
      end
    end
    if (fd != 0) $fclose(fd);

    repeat (10) @(negedge CLK2);
    $display("checks %0d, errors %0d, aborts %0d", checks, errors, aborts);
    if (errors == 0 && aborts == 0 && checks > 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule
